// File: common/dcache_macros.svh
// dcache geometry
// address widths, word widths and the tag/index/offset split
// for the two-way set-associative data cache

`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// core address and data
`define DCACHE_ADDR_W   64
`define DCACHE_WORD_W   64
`define DCACHE_STRB_W   8

// address split, tag | index | offset
`define DCACHE_OFFSET_W 3
`define DCACHE_INDEX_W  6
`define DCACHE_TAG_W    55

// one line per set per way
`define DCACHE_SETS     64

`endif

// File: common/dcache_core_pkg.sv
// dcache core-side types
// vector types for the address split, the core request and
// response structs, and the controller state encoding

`include "dcache_macros.svh"

package dcache_core_pkg;

    typedef logic [`DCACHE_ADDR_W-1:0]  addr_t;
    typedef logic [`DCACHE_WORD_W-1:0]  word_t;
    typedef logic [`DCACHE_STRB_W-1:0]  strb_t;
    typedef logic [`DCACHE_TAG_W-1:0]   tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0] index_t;
    typedef logic                       way_t;

    // rd and wr are levels, held until ready
    typedef struct packed {
        logic  rd;
        logic  wr;
        addr_t addr;
        word_t wdata;
        strb_t strb;
    } cpu_req_t;

    typedef struct packed {
        logic  ready;
        word_t rdata;
    } cpu_rsp_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL
    } ctrl_state_e;

endpackage

// File: common/dcache_mem_pkg.sv
// dcache memory-side types
// operation code and the request/response structs toward memory

`include "dcache_macros.svh"

package dcache_mem_pkg;

    import dcache_core_pkg::*;

    typedef enum logic {
        MEM_REFILL    = 1'b0,
        MEM_WRITEBACK = 1'b1
    } mem_op_e;

    // valid held with op, addr and wdata until ready
    typedef struct packed {
        logic    valid;
        mem_op_e op;
        addr_t   addr;
        word_t   wdata;
    } mem_req_t;

    typedef struct packed {
        logic  ready;
        word_t rdata;
    } mem_rsp_t;

endpackage

// File: dcache_store/dcache_way_store.sv
// dcache way store
// tag, data, valid and dirty arrays of one way
// registered read and tag compare against the request tag

`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_way_store
    import dcache_core_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n_i,
    input  index_t index_i,
    input  tag_t   tag_i,
    input  strb_t  wr_strb_i,
    input  word_t  wr_data_i,
    input  logic   fill_i,
    input  logic   mark_dirty_i,
    output logic   hit_o,
    output logic   valid_o,
    output logic   dirty_o,
    output tag_t   tag_o,
    output word_t  rdata_o
);

    tag_t                    tag_mem  [`DCACHE_SETS];
    word_t                   data_mem [`DCACHE_SETS];
    logic [`DCACHE_SETS-1:0] valid_q;
    logic [`DCACHE_SETS-1:0] dirty_q;

    // tag and data payload
    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_mem[index_i] <= tag_i;
        end
        for (int b = 0; b < `DCACHE_STRB_W; b++) begin
            if (wr_strb_i[b]) begin
                data_mem[index_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
            end
        end
        tag_o   <= tag_mem[index_i];
        rdata_o <= data_mem[index_i];
    end

    // line state
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            dirty_q <= '0;
            valid_o <= 1'b0;
            dirty_o <= 1'b0;
        end else begin
            if (fill_i) begin
                valid_q[index_i] <= 1'b1;
                dirty_q[index_i] <= 1'b0;
            end else if (mark_dirty_i) begin
                dirty_q[index_i] <= 1'b1;
            end
            valid_o <= valid_q[index_i];
            dirty_o <= dirty_q[index_i];
        end
    end

    assign hit_o = valid_o && (tag_o == tag_i);

endmodule

// File: dcache_ctrl/dcache_replace.sv
// dcache replacement
// one LRU bit per set, naming the least recently used way
// victim is the first invalid way, else the LRU way

`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_replace
    import dcache_core_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  index_t     index_i,
    input  logic [1:0] valid_i,
    input  logic       touch_i,
    input  way_t       touch_way_i,
    output way_t       victim_o
);

    logic [`DCACHE_SETS-1:0] lru_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            lru_q <= '0;
        end else if (touch_i) begin
            // the other way becomes least recent
            lru_q[index_i] <= ~touch_way_i;
        end
    end

    always_comb begin
        if (!valid_i[0]) begin
            victim_o = 1'b0;
        end else if (!valid_i[1]) begin
            victim_o = 1'b1;
        end else begin
            victim_o = lru_q[index_i];
        end
    end

endmodule

// File: dcache_ctrl/dcache_ctrl.sv
// dcache controller
// serves one core request at a time: lookup, write-back of a
// dirty victim, refill from memory, then a replayed lookup

`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_ctrl
    import dcache_core_pkg::*;
    import dcache_mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  cpu_req_t    cpu_req_i,
    output cpu_rsp_t    cpu_rsp_o,
    output mem_req_t    mem_req_o,
    input  mem_rsp_t    mem_rsp_i,
    input  logic [1:0]  way_hit_i,
    input  logic [1:0]  way_valid_i,
    input  logic [1:0]  way_dirty_i,
    input  tag_t [1:0]  way_tag_i,
    input  word_t [1:0] way_rdata_i,
    input  way_t        victim_i,
    output strb_t [1:0] wr_strb_o,
    output word_t       wr_data_o,
    output logic [1:0]  fill_o,
    output logic [1:0]  mark_dirty_o,
    output logic        touch_o,
    output way_t        touch_way_o
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    way_t        victim_q;
    way_t        hit_way;
    index_t      req_index;
    logic        hit;
    logic        victim_dirty;
    logic        refill_done;

    assign req_index    = cpu_req_i.addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign hit          = |way_hit_i;
    // at most one way hits
    assign hit_way      = way_hit_i[1];
    assign victim_dirty = way_valid_i[victim_i] & way_dirty_i[victim_i];
    assign refill_done  = (state_q == ST_REFILL) && mem_rsp_i.ready;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q  <= ST_IDLE;
            victim_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // victim fixed for the whole miss
            if ((state_q == ST_LOOKUP) && !hit) begin
                victim_q <= victim_i;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (cpu_req_i.rd || cpu_req_i.wr) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (hit) begin
                    state_d = ST_IDLE;
                end else if (victim_dirty) begin
                    state_d = ST_WRITEBACK;
                end else begin
                    state_d = ST_REFILL;
                end
            end
            ST_WRITEBACK: begin
                if (mem_rsp_i.ready) begin
                    state_d = ST_REFILL;
                end
            end
            ST_REFILL: begin
                // back through idle so the arrays are read again
                if (mem_rsp_i.ready) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // core response
    always_comb begin
        cpu_rsp_o.ready = (state_q == ST_LOOKUP) && hit;
        cpu_rsp_o.rdata = way_rdata_i[hit_way];
    end

    // memory request, line-aligned
    always_comb begin
        mem_req_o = '0;
        case (state_q)
            ST_WRITEBACK: begin
                mem_req_o.valid = 1'b1;
                mem_req_o.op    = MEM_WRITEBACK;
                mem_req_o.addr  = {way_tag_i[victim_q], req_index, {`DCACHE_OFFSET_W{1'b0}}};
                mem_req_o.wdata = way_rdata_i[victim_q];
            end
            ST_REFILL: begin
                mem_req_o.valid = 1'b1;
                mem_req_o.op    = MEM_REFILL;
                mem_req_o.addr  = {cpu_req_i.addr[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W],
                                   {`DCACHE_OFFSET_W{1'b0}}};
            end
            default: begin
                mem_req_o = '0;
            end
        endcase
    end

    // array updates and LRU touch
    always_comb begin
        wr_strb_o    = '0;
        fill_o       = '0;
        mark_dirty_o = '0;
        touch_o      = 1'b0;
        touch_way_o  = hit_way;
        wr_data_o    = cpu_req_i.wdata;
        if ((state_q == ST_LOOKUP) && hit) begin
            touch_o = 1'b1;
            if (cpu_req_i.wr) begin
                wr_strb_o[hit_way]    = cpu_req_i.strb;
                mark_dirty_o[hit_way] = 1'b1;
            end
        end
        if (refill_done) begin
            wr_data_o           = mem_rsp_i.rdata;
            wr_strb_o[victim_q] = '1;
            fill_o[victim_q]    = 1'b1;
            touch_o             = 1'b1;
            touch_way_o         = victim_q;
        end
    end

endmodule

// File: source/dcache.sv
// dcache top level
// two-way set-associative write-back data cache, one word per line
// splits the request address and wires controller, LRU and ways

`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache
    import dcache_core_pkg::*;
    import dcache_mem_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  cpu_req_t cpu_req_i,
    output cpu_rsp_t cpu_rsp_o,
    output mem_req_t mem_req_o,
    input  mem_rsp_t mem_rsp_i
);

    tag_t            req_tag;
    index_t          req_index;
    logic [1:0]      way_hit;
    logic [1:0]      way_valid;
    logic [1:0]      way_dirty;
    tag_t  [1:0]     way_tag;
    word_t [1:0]     way_rdata;
    strb_t [1:0]     wr_strb;
    word_t           wr_data;
    logic [1:0]      fill;
    logic [1:0]      mark_dirty;
    logic            touch;
    way_t            touch_way;
    way_t            victim;

    assign req_tag   = cpu_req_i.addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
    assign req_index = cpu_req_i.addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .cpu_req_i    (cpu_req_i),
        .cpu_rsp_o    (cpu_rsp_o),
        .mem_req_o    (mem_req_o),
        .mem_rsp_i    (mem_rsp_i),
        .way_hit_i    (way_hit),
        .way_valid_i  (way_valid),
        .way_dirty_i  (way_dirty),
        .way_tag_i    (way_tag),
        .way_rdata_i  (way_rdata),
        .victim_i     (victim),
        .wr_strb_o    (wr_strb),
        .wr_data_o    (wr_data),
        .fill_o       (fill),
        .mark_dirty_o (mark_dirty),
        .touch_o      (touch),
        .touch_way_o  (touch_way)
    );

    dcache_replace u_replace (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .index_i     (req_index),
        .valid_i     (way_valid),
        .touch_i     (touch),
        .touch_way_i (touch_way),
        .victim_o    (victim)
    );

    dcache_way_store u_way0 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .index_i      (req_index),
        .tag_i        (req_tag),
        .wr_strb_i    (wr_strb[0]),
        .wr_data_i    (wr_data),
        .fill_i       (fill[0]),
        .mark_dirty_i (mark_dirty[0]),
        .hit_o        (way_hit[0]),
        .valid_o      (way_valid[0]),
        .dirty_o      (way_dirty[0]),
        .tag_o        (way_tag[0]),
        .rdata_o      (way_rdata[0])
    );

    dcache_way_store u_way1 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .index_i      (req_index),
        .tag_i        (req_tag),
        .wr_strb_i    (wr_strb[1]),
        .wr_data_i    (wr_data),
        .fill_i       (fill[1]),
        .mark_dirty_i (mark_dirty[1]),
        .hit_o        (way_hit[1]),
        .valid_o      (way_valid[1]),
        .dirty_o      (way_dirty[1]),
        .tag_o        (way_tag[1]),
        .rdata_o      (way_rdata[1])
    );

endmodule

// File: verification/dcache_assertions.sv
// dcache protocol checker
// concurrent checks on the core ready pulse and the memory request
// bound into the cache top level

`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_assertions
    import dcache_core_pkg::*;
    import dcache_mem_pkg::*;
(
    input logic     clk,
    input logic     rst_n_i,
    input cpu_rsp_t cpu_rsp_i,
    input mem_req_t mem_req_i,
    input mem_rsp_t mem_rsp_i
);

    // failure count, watched by the testbench
    int unsigned assert_failures = 0;

    ready_single_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        cpu_rsp_i.ready |=> !cpu_rsp_i.ready)
    else begin
        assert_failures++;
        $error("core ready high for two cycles in a row");
    end

    // request held until the memory answers
    mem_req_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        (mem_req_i.valid && !mem_rsp_i.ready) |=>
            (mem_req_i.valid && $stable(mem_req_i.addr) && $stable(mem_req_i.op)))
    else begin
        assert_failures++;
        $error("memory request dropped or changed before ready");
    end

    mem_addr_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_req_i.valid |-> (mem_req_i.addr[`DCACHE_OFFSET_W-1:0] == '0))
    else begin
        assert_failures++;
        $error("memory address not line-aligned");
    end

    mem_idle_after_reset: assert property (@(posedge clk)
        !rst_n_i |=> !mem_req_i.valid)
    else begin
        assert_failures++;
        $error("memory request valid right after reset");
    end

endmodule

bind dcache dcache_assertions u_assertions (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .cpu_rsp_i (cpu_rsp_o),
    .mem_req_i (mem_req_o),
    .mem_rsp_i (mem_rsp_i)
);

// File: verification/dcache_tb.sv
// dcache testbench
// directed tests for hits, misses, evictions and a random run
// behavioral memory on the memory port, reference model of the cache

`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_tb
    import dcache_core_pkg::*;
    import dcache_mem_pkg::*;
();

    localparam int CLK_HALF       = 20;
    localparam int RESET_CYCLES   = 10;
    localparam int ACCESS_TIMEOUT = 200;
    localparam int RANDOM_OPS     = 300;

    localparam addr_t ADDR_A = {55'h1a2b, 6'd5, 3'd4};
    localparam addr_t ADDR_B = {55'h2c3d, 6'd5, 3'd0};
    localparam addr_t ADDR_C = {55'h3e4f, 6'd5, 3'd0};
    localparam addr_t ADDR_D = {55'h0051, 6'd9, 3'd0};
    localparam addr_t ADDR_E = {55'h0052, 6'd9, 3'd0};
    localparam addr_t ADDR_F = {55'h0053, 6'd9, 3'd0};
    localparam addr_t ADDR_G = {55'h0054, 6'd9, 3'd2};

    logic     clk;
    logic     rst_n;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    // memory behind the cache and its request log
    word_t   backing [addr_t];
    mem_op_e seen_op [$];
    addr_t   seen_addr [$];
    word_t   seen_wdata [$];

    // model: CPU view of memory, per-set way state, expected traffic
    word_t      image [addr_t];
    logic [1:0] mdl_valid [`DCACHE_SETS];
    logic [1:0] mdl_dirty [`DCACHE_SETS];
    tag_t       mdl_tag [`DCACHE_SETS][2];
    way_t       mdl_lru [`DCACHE_SETS];
    mem_op_e    exp_op [$];
    addr_t      exp_addr [$];
    word_t      exp_wdata [$];

    dcache u_dut (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .cpu_req_i (cpu_req),
        .cpu_rsp_o (cpu_rsp),
        .mem_req_o (mem_req),
        .mem_rsp_i (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_HALF) clk = ~clk;
        end
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
            stop_on_error($sformatf("mismatch in %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp)
            stop_on_error($sformatf("mismatch in %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_op(input string name, input mem_op_e exp, input mem_op_e act);
        if (act !== exp)
            stop_on_error($sformatf("mismatch in %s: expected %s, actual %s",
                                    name, exp.name(), act.name()));
    endtask

    // untouched memory holds a word derived from its whole address
    function automatic word_t fill_word(input addr_t a);
        return a ^ {a[31:0], a[63:32]} ^ 64'h9e37_79b9_7f4a_7c15;
    endfunction

    function automatic addr_t line_of(input addr_t a);
        return {a[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W], {`DCACHE_OFFSET_W{1'b0}}};
    endfunction

    function automatic word_t image_word(input addr_t a);
        return image.exists(line_of(a)) ? image[line_of(a)] : fill_word(line_of(a));
    endfunction

    function automatic word_t backing_word(input addr_t a);
        return backing.exists(a) ? backing[a] : fill_word(a);
    endfunction

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input strb_t s);
        word_t r;
        r = old_w;
        for (int b = 0; b < `DCACHE_STRB_W; b++) begin
            if (s[b])
                r[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return r;
    endfunction

    // replacement: invalid way first, way 0 preferred, else LRU way
    task automatic predict_access(input addr_t a, input logic is_wr);
        tag_t   t;
        index_t i;
        way_t   w;
        logic   found;
        addr_t  victim_addr;
        t = a[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
        i = a[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
        found = 1'b0;
        w = 1'b0;
        for (int k = 0; k < 2; k++) begin
            if (mdl_valid[i][k] && mdl_tag[i][k] == t) begin
                found = 1'b1;
                w = way_t'(k);
            end
        end
        if (!found) begin
            if (!mdl_valid[i][0])
                w = 1'b0;
            else if (!mdl_valid[i][1])
                w = 1'b1;
            else
                w = mdl_lru[i];
            if (mdl_valid[i][w] && mdl_dirty[i][w]) begin
                victim_addr = {mdl_tag[i][w], i, {`DCACHE_OFFSET_W{1'b0}}};
                exp_op.push_back(MEM_WRITEBACK);
                exp_addr.push_back(victim_addr);
                exp_wdata.push_back(image_word(victim_addr));
            end
            exp_op.push_back(MEM_REFILL);
            exp_addr.push_back(line_of(a));
            exp_wdata.push_back('0);
            mdl_tag[i][w]   = t;
            mdl_valid[i][w] = 1'b1;
            mdl_dirty[i][w] = 1'b0;
        end
        mdl_lru[i] = ~w;
        if (is_wr)
            mdl_dirty[i][w] = 1'b1;
    endtask

    task automatic check_traffic(input string name);
        if (seen_op.size() != exp_op.size())
            stop_on_error($sformatf("mismatch in %s memory request count: expected %0d, actual %0d",
                                    name, exp_op.size(), seen_op.size()));
        for (int k = 0; k < exp_op.size(); k++) begin
            check_op(name, exp_op[k], seen_op[k]);
            check_addr(name, exp_addr[k], seen_addr[k]);
            if (exp_op[k] == MEM_WRITEBACK)
                check_word(name, exp_wdata[k], seen_wdata[k]);
        end
    endtask

    // one core request, held until the ready pulse
    task automatic access(input string name, input logic is_wr, input addr_t a,
                          input word_t wd, input strb_t s);
        int    waited;
        word_t got;
        exp_op.delete();
        exp_addr.delete();
        exp_wdata.delete();
        seen_op.delete();
        seen_addr.delete();
        seen_wdata.delete();
        predict_access(a, is_wr);
        @(negedge clk);
        cpu_req.rd    = !is_wr;
        cpu_req.wr    = is_wr;
        cpu_req.addr  = a;
        cpu_req.wdata = wd;
        cpu_req.strb  = s;
        waited = 0;
        @(negedge clk);
        while (!cpu_rsp.ready) begin
            if (waited >= ACCESS_TIMEOUT) begin
                stop_on_error($sformatf("%s: cache gave no ready within %0d cycles",
                                        name, ACCESS_TIMEOUT));
            end else begin
                @(negedge clk);
                waited++;
            end
        end
        got = cpu_rsp.rdata;
        // request stays up until the edge that ends the ready cycle
        @(negedge clk);
        cpu_req.rd = 1'b0;
        cpu_req.wr = 1'b0;
        check_traffic(name);
        if (is_wr)
            image[line_of(a)] = merge_bytes(image_word(a), wd, s);
        else
            check_word(name, image_word(a), got);
    endtask

    task automatic test_cold_read_miss();
        access("cold_read_miss", 1'b0, ADDR_A, '0, '0);
        check_op("cold_read_miss", MEM_REFILL, seen_op[0]);
    endtask

    task automatic test_read_hit();
        access("read_hit", 1'b0, ADDR_A, '0, '0);
    endtask

    task automatic test_write_hit_strobes();
        access("write_hit", 1'b1, ADDR_A, 64'h0123_4567_89ab_cdef, 8'b1010_0101);
        access("write_hit_readback", 1'b0, ADDR_A, '0, '0);
    endtask

    task automatic test_dirty_eviction();
        access("dirty_evict_fill", 1'b0, ADDR_B, '0, '0);
        access("dirty_evict", 1'b0, ADDR_C, '0, '0);
        check_op("dirty_evict", MEM_WRITEBACK, seen_op[0]);
        check_addr("dirty_evict", line_of(ADDR_A), seen_addr[0]);
    endtask

    task automatic test_clean_eviction_write_miss();
        access("clean_evict_fill0", 1'b0, ADDR_D, '0, '0);
        access("clean_evict_fill1", 1'b0, ADDR_E, '0, '0);
        access("clean_evict", 1'b0, ADDR_F, '0, '0);
        check_op("clean_evict", MEM_REFILL, seen_op[0]);
        access("write_miss", 1'b1, ADDR_G, 64'hfeed_face_0bad_f00d, 8'b0000_1111);
        access("write_miss_readback", 1'b0, ADDR_G, '0, '0);
    endtask

    task automatic test_random_run();
        index_t      idx_pick [3] = '{6'd2, 6'd3, 6'd40};
        int unsigned pick;
        tag_t        t;
        addr_t       a;
        logic        is_wr;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            pick  = $urandom_range(2, 0);
            t     = tag_t'(55'h700 + $urandom_range(3, 0));
            a     = {t, idx_pick[pick], 3'($urandom_range(7, 0))};
            is_wr = 1'($urandom_range(1, 0));
            access($sformatf("random_run op %0d", n), is_wr, a,
                   {$urandom, $urandom}, strb_t'($urandom));
        end
    endtask

    // answers each memory request after 1 to 6 cycles
    initial begin : memory_responder
        int delay;
        mem_rsp = '0;
        forever begin
            @(negedge clk);
            mem_rsp = '0;
            if (rst_n && mem_req.valid) begin
                seen_op.push_back(mem_req.op);
                seen_addr.push_back(mem_req.addr);
                seen_wdata.push_back(mem_req.wdata);
                delay = $urandom_range(6, 1);
                repeat (delay) @(negedge clk);
                if (mem_req.op == MEM_WRITEBACK)
                    backing[mem_req.addr] = mem_req.wdata;
                else
                    mem_rsp.rdata = backing_word(mem_req.addr);
                mem_rsp.ready = 1'b1;
            end
        end
    end

    // failure count of the bound protocol checker
    always @(negedge clk) begin
        if (u_dut.u_assertions.assert_failures != 0)
            stop_on_error("a protocol assertion on the cache ports failed");
    end

    initial begin
        void'($urandom(87150));
        rst_n   = 1'b0;
        cpu_req = '0;
        for (int i = 0; i < `DCACHE_SETS; i++) begin
            mdl_valid[i] = '0;
            mdl_dirty[i] = '0;
            mdl_lru[i]   = 1'b0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        test_cold_read_miss();
        test_read_hit();
        test_write_hit_strobes();
        test_dirty_eviction();
        test_clean_eviction_write_miss();
        test_random_run();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: dcache.f
+incdir+common
common/dcache_core_pkg.sv
common/dcache_mem_pkg.sv
dcache_store/dcache_way_store.sv
dcache_ctrl/dcache_replace.sv
dcache_ctrl/dcache_ctrl.sv
source/dcache.sv
verification/dcache_assertions.sv
verification/dcache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the dcache testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module dcache_tb -Mdir obj_dir -f dcache.f \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vdcache_tb +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
